/* source/cpu6502_pkg.sv */
// 6502 execute core definitions
package cpu6502_pkg;

	// Opcode split as aaa_bbb_cc
	typedef struct packed {
		logic [2:0] operation;	// Operation within the group
		logic [2:0] mode;	// Addressing mode column
		logic [1:0] group;	// Opcode group
	} opcode_grp_t;

	// Flag opcodes split as ss_v_11000
	typedef struct packed {
		logic [1:0] flag_sel;	// Which flag
		logic       set_val;	// Set or clear
		logic [4:0] tail;	// Fixed 11000 pattern
	} opcode_flag_t;

	typedef union packed {
		opcode_grp_t  grp;
		opcode_flag_t flg;
	} opcode_t;

	// ALU operation codes
	parameter logic [3:0] OP_OR  = 4'b1100;
	parameter logic [3:0] OP_AND = 4'b1101;
	parameter logic [3:0] OP_EOR = 4'b1110;
	parameter logic [3:0] OP_ADD = 4'b0011;
	parameter logic [3:0] OP_SUB = 4'b0111;
	parameter logic [3:0] OP_ROL = 4'b1011;
	parameter logic [3:0] OP_A   = 4'b1111;

	parameter logic [7:0] OPC_ORA_IMM = 8'h09;
	parameter logic [7:0] OPC_AND_IMM = 8'h29;
	parameter logic [7:0] OPC_EOR_IMM = 8'h49;
	parameter logic [7:0] OPC_ADC_IMM = 8'h69;
	parameter logic [7:0] OPC_LDA_IMM = 8'ha9;
	parameter logic [7:0] OPC_CMP_IMM = 8'hc9;
	parameter logic [7:0] OPC_SBC_IMM = 8'he9;
	parameter logic [7:0] OPC_ASL_A   = 8'h0a;
	parameter logic [7:0] OPC_ROL_A   = 8'h2a;
	parameter logic [7:0] OPC_LSR_A   = 8'h4a;
	parameter logic [7:0] OPC_ROR_A   = 8'h6a;
	parameter logic [7:0] OPC_CLC     = 8'h18;
	parameter logic [7:0] OPC_SEC     = 8'h38;
	parameter logic [7:0] OPC_CLD     = 8'hd8;
	parameter logic [7:0] OPC_SED     = 8'hf8;
	parameter logic [7:0] OPC_CLV     = 8'hb8;

	// Status byte bit positions
	parameter logic [2:0] FLAG_C = 3'd0;
	parameter logic [2:0] FLAG_Z = 3'd1;
	parameter logic [2:0] FLAG_D = 3'd3;
	parameter logic [2:0] FLAG_V = 3'd6;
	parameter logic [2:0] FLAG_N = 3'd7;

	parameter logic [3:0] BCD_ADJ_ADC = 4'd6;	// Decimal carry correction
	parameter logic [3:0] BCD_ADJ_SBC = 4'd10;	// Decimal borrow correction, i.e. -6

	parameter logic [1:0] GRP_ALU   = 2'b01;
	parameter logic [1:0] GRP_SHIFT = 2'b10;
	parameter logic [2:0] MODE_IMM  = 3'b010;	// Immediate, or accumulator for shifts
	parameter logic [4:0] FLAG_TAIL = 5'b11000;

	parameter logic [1:0] FSEL_C = 2'b00;
	parameter logic [1:0] FSEL_V = 2'b10;
	parameter logic [1:0] FSEL_D = 2'b11;

	// Shift control carried in the operand slot
	parameter int SHIFT_ROT_BIT   = 0;
	parameter int SHIFT_RIGHT_BIT = 1;

endpackage

/* source/op_decode.sv */
`timescale 1ns/1ps
// Command accept and opcode decode
module op_decode #(
	parameter int data_width = 8
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  op_valid,
	input  cpu6502_pkg::opcode_t  opcode,
	input  logic [data_width-1:0] operand,
	input  logic                  retire,
	output logic                  op_ready,
	output logic                  dec_valid,
	output logic [3:0]            alu_op,
	output logic [data_width-1:0] dec_operand,
	output logic                  carry_force,
	output logic                  adc_sbc,
	output logic                  wr_acc,
	output logic                  upd_nz,
	output logic                  upd_c,
	output logic                  upd_v,
	output logic                  use_arith,
	output logic                  flag_write,
	output logic [1:0]            flag_sel,
	output logic                  flag_val
);
	import cpu6502_pkg::*;

	logic                  busy;		// Instruction in flight
	logic                  accept;
	logic                  is_imm;
	logic                  is_shift;
	logic                  is_flag;
	logic [3:0]            alu_op_d;
	logic [data_width-1:0] operand_d;
	logic                  carry_force_d;
	logic                  adc_sbc_d;
	logic                  wr_acc_d;
	logic                  upd_nz_d;
	logic                  upd_c_d;
	logic                  upd_v_d;
	logic                  use_arith_d;
	logic                  flag_write_d;
	logic                  flag_val_d;

	assign op_ready = ~busy;
	assign accept   = op_valid & op_ready;

	always_comb begin
		is_imm   = (opcode.grp.group == GRP_ALU) && (opcode.grp.mode == MODE_IMM);
		is_shift = (opcode.grp.group == GRP_SHIFT) && (opcode.grp.mode == MODE_IMM)
			&& !opcode.grp.operation[2];	// ASL ROL LSR ROR only
		// C, D, and V only for clear; I dropped, 98 is TYA
		is_flag  = (opcode.flg.tail == FLAG_TAIL)
			&& ((opcode.flg.flag_sel == FSEL_C) || (opcode.flg.flag_sel == FSEL_D)
			|| ((opcode.flg.flag_sel == FSEL_V) && opcode.flg.set_val));
		alu_op_d      = OP_ADD;
		operand_d     = operand;
		carry_force_d = 1'b0;
		adc_sbc_d     = 1'b0;
		wr_acc_d      = 1'b0;
		upd_nz_d      = 1'b0;
		upd_c_d       = 1'b0;
		upd_v_d       = 1'b0;
		use_arith_d   = 1'b0;
		flag_write_d  = 1'b0;
		flag_val_d    = 1'b0;
		if (is_imm) begin
			wr_acc_d = 1'b1;
			upd_nz_d = 1'b1;
			case (opcode.grp.operation)
				3'b000, 3'b001, 3'b010: alu_op_d = {2'b11, opcode.grp.operation[1:0]};
				3'b101: alu_op_d = OP_A;	// LDA passes operand
				3'b011, 3'b111: begin	// ADC, SBC
					alu_op_d    = opcode.grp.operation[2] ? OP_SUB : OP_ADD;
					adc_sbc_d   = 1'b1;
					use_arith_d = 1'b1;
					upd_c_d     = 1'b1;
					upd_v_d     = 1'b1;
				end
				3'b110: begin	// CMP, subtract with forced carry
					alu_op_d      = OP_SUB;
					carry_force_d = 1'b1;
					use_arith_d   = 1'b1;
					upd_c_d       = 1'b1;
					wr_acc_d      = 1'b0;
				end
				default: begin	// STA #imm does not exist
					wr_acc_d = 1'b0;
					upd_nz_d = 1'b0;
				end
			endcase
		end else if (is_shift) begin
			alu_op_d  = OP_ROL;
			wr_acc_d  = 1'b1;
			upd_nz_d  = 1'b1;
			upd_c_d   = 1'b1;
			operand_d = '0;	// Zero fill unless rotate
			operand_d[SHIFT_ROT_BIT]   = opcode.grp.operation[0];	// ROL, ROR
			operand_d[SHIFT_RIGHT_BIT] = opcode.grp.operation[1];	// LSR, ROR
		end else if (is_flag) begin
			flag_write_d = 1'b1;
			flag_val_d   = opcode.flg.set_val & (opcode.flg.flag_sel != FSEL_V);	// CLV clears
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy        <= 1'b0;
			dec_valid   <= 1'b0;
			alu_op      <= OP_ADD;
			carry_force <= 1'b0;
			adc_sbc     <= 1'b0;
			wr_acc      <= 1'b0;
			upd_nz      <= 1'b0;
			upd_c       <= 1'b0;
			upd_v       <= 1'b0;
			use_arith   <= 1'b0;
			flag_write  <= 1'b0;
			flag_sel    <= FSEL_C;
			flag_val    <= 1'b0;
		end else begin
			dec_valid <= accept;	// One cycle after accept
			if (accept) begin
				busy        <= 1'b1;
				alu_op      <= alu_op_d;
				carry_force <= carry_force_d;
				adc_sbc     <= adc_sbc_d;
				wr_acc      <= wr_acc_d;
				upd_nz      <= upd_nz_d;
				upd_c       <= upd_c_d;
				upd_v       <= upd_v_d;
				use_arith   <= use_arith_d;
				flag_write  <= flag_write_d;
				flag_sel    <= opcode.flg.flag_sel;
				flag_val    <= flag_val_d;
			end else if (retire) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			dec_operand <= operand_d;
	end

	// Write-back retires only its own instruction, one stage past decode
	a_retire_busy: assert property (@(posedge clk) disable iff (reset)
		retire |-> (busy && !dec_valid));

endmodule

/* source/arith_unit.sv */
`timescale 1ns/1ps
// Binary and decimal adder
module arith_unit #(
	parameter int data_width = 8
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  dec_valid,
	input  logic [3:0]            alu_op,
	input  logic [data_width-1:0] a,
	input  logic [data_width-1:0] b,
	input  logic                  carry_flag,
	input  logic                  carry_force,
	input  logic                  adc_sbc,
	input  logic                  decimal_flag,
	output logic [data_width-1:0] arith_result,
	output logic                  arith_carry,
	output logic                  arith_overflow
);
	import cpu6502_pkg::*;

	logic                  subtract;
	logic                  carry_in;
	logic [data_width-1:0] b_in;
	logic                  bcd_mode;	// ADC or SBC with D set
	logic                  bcd_add;
	logic [4:0]            lo_sum;
	logic [data_width-4:0] hi_sum;
	logic                  half_carry;
	logic                  carry_out;
	logic [data_width:0]   bin_sum;
	logic                  overflow;
	logic [3:0]            adj_lo;
	logic [3:0]            adj_hi;
	logic [data_width-1:0] result;

	always_comb begin
		subtract   = (alu_op == OP_SUB);
		carry_in   = carry_force | carry_flag;	// CMP forces 1
		b_in       = subtract ? ~b : b;	// A + ~B + C for subtract
		bcd_mode   = adc_sbc & decimal_flag;
		bcd_add    = bcd_mode & ~subtract;
		lo_sum     = {1'b0, a[3:0]} + {1'b0, b_in[3:0]} + {4'b0, carry_in};
		half_carry = bcd_add ? (lo_sum > 5'd9) : lo_sum[4];	// Decimal digit carry
		hi_sum     = {1'b0, a[data_width-1:4]} + {1'b0, b_in[data_width-1:4]}
			+ (data_width-3)'(half_carry);
		carry_out  = bcd_add ? (hi_sum > (data_width-3)'(9)) : hi_sum[data_width-4];
		bin_sum    = {1'b0, a} + {1'b0, b_in} + (data_width+1)'(carry_in);
		// Same-sign inputs, different-sign sum
		overflow   = (a[data_width-1] ~^ b_in[data_width-1])
			& (a[data_width-1] ^ bin_sum[data_width-1]);
		adj_lo = 4'd0;
		adj_hi = 4'd0;
		if (bcd_mode) begin
			if (bcd_add) begin
				if (half_carry)
					adj_lo = BCD_ADJ_ADC;
				if (carry_out)
					adj_hi = BCD_ADJ_ADC;
			end else begin
				if (!half_carry)	// Borrow from low digit
					adj_lo = BCD_ADJ_SBC;
				if (!carry_out)
					adj_hi = BCD_ADJ_SBC;
			end
		end
		result = {hi_sum[data_width-5:0] + (data_width-4)'(adj_hi), lo_sum[3:0] + adj_lo};
	end

	always_ff @(posedge clk) begin
		if (dec_valid) begin
			arith_result   <= result;
			arith_carry    <= carry_out;
			arith_overflow <= overflow;
		end
	end

	// Nibble adjust only for a decoded ADC or SBC, never for CMP
	a_bcd_only_adc_sbc: assert property (@(posedge clk) disable iff (reset)
		(dec_valid && bcd_mode) |-> (((alu_op == OP_ADD) || subtract) && !carry_force));

endmodule

/* source/logic_shift_unit.sv */
`timescale 1ns/1ps
// Logic and shift unit
module logic_shift_unit #(
	parameter int data_width = 8
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  dec_valid,
	input  logic [3:0]            alu_op,
	input  logic [data_width-1:0] a,
	input  logic [data_width-1:0] b,
	input  logic                  carry_flag,
	output logic [data_width-1:0] logic_result,
	output logic                  logic_carry
);
	import cpu6502_pkg::*;

	logic                  fill;	// Bit shifted into vacated end
	logic [data_width-1:0] result_d;
	logic                  carry_d;

	always_comb begin
		fill    = b[SHIFT_ROT_BIT] & carry_flag;	// Zero for ASL, LSR
		carry_d = 1'b0;
		case (alu_op)
			OP_OR:  result_d = a | b;
			OP_AND: result_d = a & b;
			OP_EOR: result_d = a ^ b;
			OP_A:   result_d = b;	// Load
			OP_ROL: begin
				if (b[SHIFT_RIGHT_BIT]) begin
					result_d = {fill, a[data_width-1:1]};
					carry_d  = a[0];
				end else begin
					result_d = {a[data_width-2:0], fill};
					carry_d  = a[data_width-1];
				end
			end
			default: result_d = a;	// Arithmetic op, unused here
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			logic_result <= '0;
			logic_carry  <= 1'b0;
		end else if (dec_valid) begin
			logic_result <= result_d;
			logic_carry  <= carry_d;
		end
	end

endmodule

/* source/status_writeback.sv */
`timescale 1ns/1ps
// Accumulator and status write-back
module status_writeback #(
	parameter int data_width = 8
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  dec_valid,
	input  logic                  wr_acc,
	input  logic                  upd_nz,
	input  logic                  upd_c,
	input  logic                  upd_v,
	input  logic                  use_arith,
	input  logic                  flag_write,
	input  logic [1:0]            flag_sel,
	input  logic                  flag_val,
	input  logic [data_width-1:0] arith_result,
	input  logic                  arith_carry,
	input  logic                  arith_overflow,
	input  logic [data_width-1:0] logic_result,
	input  logic                  logic_carry,
	output logic                  retire,
	output logic                  done,
	output logic [data_width-1:0] acc,
	output logic [7:0]            status,
	output logic                  carry_flag,
	output logic                  decimal_flag
);
	import cpu6502_pkg::*;

	logic                  wr_acc_q;
	logic                  upd_nz_q;
	logic                  upd_c_q;
	logic                  upd_v_q;
	logic                  use_arith_q;
	logic                  flag_write_q;
	logic [1:0]            flag_sel_q;
	logic                  flag_val_q;
	logic                  flag_z;
	logic                  flag_v;
	logic                  flag_n;
	logic [data_width-1:0] result;
	logic                  result_carry;

	assign result       = use_arith_q ? arith_result : logic_result;
	assign result_carry = use_arith_q ? arith_carry : logic_carry;

	// Control one stage behind decode, lines up with unit outputs
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			retire       <= 1'b0;
			wr_acc_q     <= 1'b0;
			upd_nz_q     <= 1'b0;
			upd_c_q      <= 1'b0;
			upd_v_q      <= 1'b0;
			use_arith_q  <= 1'b0;
			flag_write_q <= 1'b0;
			flag_sel_q   <= FSEL_C;
			flag_val_q   <= 1'b0;
		end else begin
			retire <= dec_valid;
			if (dec_valid) begin
				wr_acc_q     <= wr_acc;
				upd_nz_q     <= upd_nz;
				upd_c_q      <= upd_c;
				upd_v_q      <= upd_v;
				use_arith_q  <= use_arith;
				flag_write_q <= flag_write;
				flag_sel_q   <= flag_sel;
				flag_val_q   <= flag_val;
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			done         <= 1'b0;
			acc          <= '0;
			carry_flag   <= 1'b0;
			decimal_flag <= 1'b0;
			flag_z       <= 1'b0;
			flag_v       <= 1'b0;
			flag_n       <= 1'b0;
		end else begin
			done <= retire;
			if (retire) begin
				if (wr_acc_q)	// Not for CMP
					acc <= result;
				if (upd_nz_q) begin
					flag_n <= result[data_width-1];
					flag_z <= (result == '0);
				end
				if (upd_c_q)
					carry_flag <= result_carry;
				if (upd_v_q)
					flag_v <= arith_overflow;
				if (flag_write_q) begin
					case (flag_sel_q)
						FSEL_C:  carry_flag   <= flag_val_q;
						FSEL_D:  decimal_flag <= flag_val_q;
						default: flag_v       <= flag_val_q;	// CLV
					endcase
				end
			end
		end
	end

	always_comb begin
		status         = 8'h00;	// Bits 5, 4 and 2 stay clear
		status[FLAG_C] = carry_flag;
		status[FLAG_Z] = flag_z;
		status[FLAG_D] = decimal_flag;
		status[FLAG_V] = flag_v;
		status[FLAG_N] = flag_n;
	end

	a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done);

endmodule

/* source/alu_exec_top.sv */
`timescale 1ns/1ps
// 6502 execute core top
module alu_exec_top #(
	parameter int data_width = 8
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  op_valid,
	input  logic [7:0]            opcode,
	input  logic [data_width-1:0] operand,
	output logic                  op_ready,
	output logic                  done,
	output logic [data_width-1:0] acc,
	output logic [7:0]            status
);
	logic                  dec_valid;
	logic [3:0]            alu_op;
	logic [data_width-1:0] dec_operand;
	logic                  carry_force;
	logic                  adc_sbc;
	logic                  wr_acc;
	logic                  upd_nz;
	logic                  upd_c;
	logic                  upd_v;
	logic                  use_arith;
	logic                  flag_write;
	logic [1:0]            flag_sel;
	logic                  flag_val;
	logic                  retire;
	logic                  carry_flag;
	logic                  decimal_flag;
	logic [data_width-1:0] arith_result;
	logic                  arith_carry;
	logic                  arith_overflow;
	logic [data_width-1:0] logic_result;
	logic                  logic_carry;

	op_decode #(.data_width(data_width)) u_decode (
		.clk(clk), .reset(reset), .op_valid(op_valid), .opcode(opcode),
		.operand(operand), .retire(retire), .op_ready(op_ready), .dec_valid(dec_valid),
		.alu_op(alu_op), .dec_operand(dec_operand), .carry_force(carry_force),
		.adc_sbc(adc_sbc), .wr_acc(wr_acc), .upd_nz(upd_nz), .upd_c(upd_c),
		.upd_v(upd_v), .use_arith(use_arith), .flag_write(flag_write),
		.flag_sel(flag_sel), .flag_val(flag_val)
	);

	arith_unit #(.data_width(data_width)) u_arith (
		.clk(clk), .reset(reset), .dec_valid(dec_valid), .alu_op(alu_op),
		.a(acc), .b(dec_operand), .carry_flag(carry_flag), .carry_force(carry_force),
		.adc_sbc(adc_sbc), .decimal_flag(decimal_flag), .arith_result(arith_result),
		.arith_carry(arith_carry), .arith_overflow(arith_overflow)
	);

	logic_shift_unit #(.data_width(data_width)) u_logic (
		.clk(clk), .reset(reset), .dec_valid(dec_valid), .alu_op(alu_op),
		.a(acc), .b(dec_operand), .carry_flag(carry_flag),
		.logic_result(logic_result), .logic_carry(logic_carry)
	);

	status_writeback #(.data_width(data_width)) u_writeback (
		.clk(clk), .reset(reset), .dec_valid(dec_valid), .wr_acc(wr_acc),
		.upd_nz(upd_nz), .upd_c(upd_c), .upd_v(upd_v), .use_arith(use_arith),
		.flag_write(flag_write), .flag_sel(flag_sel), .flag_val(flag_val),
		.arith_result(arith_result), .arith_carry(arith_carry),
		.arith_overflow(arith_overflow), .logic_result(logic_result),
		.logic_carry(logic_carry), .retire(retire), .done(done), .acc(acc),
		.status(status), .carry_flag(carry_flag), .decimal_flag(decimal_flag)
	);

endmodule

/* dv/tb_alu_exec.sv */
`timescale 1ns/1ps
// Execute core testbench
module tb_alu_exec;
	import cpu6502_pkg::*;

	localparam int TIMEOUT_CYCLES = 20;	// Per wait, in clock cycles

	logic       clk;
	logic       reset;
	logic       op_valid;
	logic [7:0] opcode;
	logic [7:0] operand;
	logic       op_ready;
	logic       done;
	logic [7:0] acc;
	logic [7:0] status;

	logic [7:0]  model_acc;	// Architectural state as the testbench sees it
	logic [7:0]  model_status;
	logic [7:0]  exp_acc;
	logic [7:0]  exp_status;
	string       test_name;
	int          issued_count;
	int          checked_count;
	int unsigned seed_val;
	logic [7:0]  kept_ops [0:14];	// Logic 0-3, arith 4-6, shifts 7-10, flags 11-14

	alu_exec_top #(.data_width(8)) u_dut (
		.clk(clk), .reset(reset), .op_valid(op_valid), .opcode(opcode),
		.operand(operand), .op_ready(op_ready), .done(done), .acc(acc),
		.status(status)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// 6502 semantics for the kept instructions, returns {acc, status}
	function automatic logic [15:0] expected_state(input logic [7:0] opc,
			input logic [7:0] opd, input logic [7:0] a, input logic [7:0] st);
		logic [7:0] r;
		logic [7:0] s;
		logic [7:0] b;
		logic [8:0] sum;
		logic       cin;
		logic       nz;
		int         da;
		int         db;
		int         dr;
		r  = a;
		s  = st;
		nz = 1'b1;
		case (opc)
			OPC_ORA_IMM: r = a | opd;
			OPC_AND_IMM: r = a & opd;
			OPC_EOR_IMM: r = a ^ opd;
			OPC_LDA_IMM: r = opd;
			OPC_ADC_IMM, OPC_SBC_IMM, OPC_CMP_IMM: begin
				b   = (opc == OPC_ADC_IMM) ? opd : ~opd;	// Subtract as A + ~B + C
				cin = (opc == OPC_CMP_IMM) ? 1'b1 : st[FLAG_C];
				sum = {1'b0, a} + {1'b0, b} + 9'(cin);
				r   = sum[7:0];
				s[FLAG_C] = sum[8];	// Carry set means no borrow
				if (opc != OPC_CMP_IMM)
					s[FLAG_V] = (a[7] == b[7]) && (a[7] != sum[7]);	// Binary overflow
				if (st[FLAG_D] && (opc != OPC_CMP_IMM)) begin
					da = 10 * int'(a[7:4]) + int'(a[3:0]);
					db = 10 * int'(opd[7:4]) + int'(opd[3:0]);
					if (opc == OPC_ADC_IMM) begin
						dr = da + db + int'(st[FLAG_C]);
						s[FLAG_C] = (dr > 99);	// Decimal carry
						dr = dr % 100;
					end else begin
						dr = da - db - (st[FLAG_C] ? 0 : 1);
						s[FLAG_C] = (dr >= 0);	// No decimal borrow
						dr = (dr + 100) % 100;
					end
					r = {4'(dr / 10), 4'(dr % 10)};
				end
			end
			OPC_ASL_A: begin
				s[FLAG_C] = a[7];
				r = {a[6:0], 1'b0};
			end
			OPC_ROL_A: begin
				s[FLAG_C] = a[7];
				r = {a[6:0], st[FLAG_C]};	// Old carry in at bit 0
			end
			OPC_LSR_A: begin
				s[FLAG_C] = a[0];
				r = {1'b0, a[7:1]};
			end
			OPC_ROR_A: begin
				s[FLAG_C] = a[0];
				r = {st[FLAG_C], a[7:1]};
			end
			default: begin
				nz = 1'b0;
				case (opc)
					OPC_CLC: s[FLAG_C] = 1'b0;
					OPC_SEC: s[FLAG_C] = 1'b1;
					OPC_CLD: s[FLAG_D] = 1'b0;
					OPC_SED: s[FLAG_D] = 1'b1;
					OPC_CLV: s[FLAG_V] = 1'b0;
					default: ;	// Unknown opcode, state unchanged
				endcase
			end
		endcase
		if (nz) begin
			s[FLAG_N] = r[7];
			s[FLAG_Z] = (r == 8'h00);
		end
		if (opc == OPC_CMP_IMM)
			r = a;	// Compare only sets flags
		return {r, s};
	endfunction

	function automatic logic [7:0] random_bcd();
		return {4'($urandom % 10), 4'($urandom % 10)};
	endfunction

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
			$display("Simulation finished: FAIL");
			$fatal(1, "Mismatch in %s", name);
		end
	endtask

	task automatic abort_run(input string reason);
		$display("Error: %s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "Run aborted");
	endtask

	// Issue one opcode and follow it to done
	task automatic run_op(input string name, input logic [7:0] opc, input logic [7:0] opd);
		int wait_cnt;
		int lat;
		@(negedge clk);
		test_name = name;
		{exp_acc, exp_status} = expected_state(opc, opd, model_acc, model_status);
		model_acc    = exp_acc;
		model_status = exp_status;
		issued_count++;
		op_valid = 1'b1;
		opcode   = opc;
		operand  = opd;
		wait_cnt = 0;
		while (!op_ready) begin
			@(negedge clk);
			wait_cnt++;
			if (wait_cnt > TIMEOUT_CYCLES)
				abort_run("op_ready stayed low, the instruction was never accepted");
		end
		@(negedge clk);	// Accepted at the rising edge just passed
		op_valid = 1'b0;
		lat = 1;
		while (!done) begin
			compare_value($sformatf("%s op_ready in flight", name), 32'd0, 32'(op_ready));
			@(negedge clk);
			lat++;
			if (lat > TIMEOUT_CYCLES)
				abort_run("done never rose after an accepted instruction");
		end
		compare_value($sformatf("%s latency", name), 32'd3, 32'(lat));
		compare_value($sformatf("%s op_ready at done", name), 32'd1, 32'(op_ready));
	endtask

	// Result checker, runs on every done pulse
	always @(negedge clk) begin
		if (!reset && done) begin
			if (checked_count >= issued_count)
				abort_run("done pulsed with no instruction in flight");
			else begin
				compare_value($sformatf("%s acc", test_name), 32'(exp_acc), 32'(acc));
				compare_value($sformatf("%s status", test_name), 32'(exp_status), 32'(status));
				checked_count++;
			end
		end
	end

	initial begin : stimulus
		logic [7:0] opc;
		int         i;
		seed_val      = $urandom(32'h33da2fba);
		reset         = 1'b1;
		op_valid      = 1'b0;
		opcode        = 8'h00;
		operand       = 8'h00;
		model_acc     = 8'h00;
		model_status  = 8'h00;
		exp_acc       = 8'h00;
		exp_status    = 8'h00;
		test_name     = "idle";
		issued_count  = 0;
		checked_count = 0;
		kept_ops      = '{OPC_ORA_IMM, OPC_AND_IMM, OPC_EOR_IMM, OPC_LDA_IMM,
			OPC_ADC_IMM, OPC_SBC_IMM, OPC_CMP_IMM, OPC_ASL_A, OPC_ROL_A, OPC_LSR_A,
			OPC_ROR_A, OPC_CLC, OPC_SEC, OPC_CLD, OPC_CLV};
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		compare_value("reset op_ready", 32'd1, 32'(op_ready));
		compare_value("reset done", 32'd0, 32'(done));
		compare_value("reset acc", 32'd0, 32'(acc));
		compare_value("reset status", 32'd0, 32'(status));
		for (i = 0; i < 40; i++) begin	// Logic group and loads, C must hold
			run_op("logic carry", ($urandom % 2) ? OPC_SEC : OPC_CLC, 8'h00);
			run_op("logic imm", kept_ops[int'($urandom % 4)], 8'($urandom));
		end
		for (i = 0; i < 50; i++) begin	// Binary add, subtract, compare
			run_op("arith load", OPC_LDA_IMM, 8'($urandom));
			run_op("arith carry", ($urandom % 2) ? OPC_SEC : OPC_CLC, 8'h00);
			run_op("arith binary", kept_ops[4 + int'($urandom % 3)], 8'($urandom));
		end
		for (i = 0; i < 40; i++) begin
			if (i % 4 == 0)
				run_op("shift load", OPC_LDA_IMM, 8'($urandom));
			run_op("shift carry", ($urandom % 2) ? OPC_SEC : OPC_CLC, 8'h00);
			run_op("shift acc", kept_ops[7 + int'($urandom % 4)], 8'($urandom));
		end
		run_op("decimal on", OPC_SED, 8'h00);
		for (i = 0; i < 40; i++) begin	// Valid BCD only
			run_op("bcd load", OPC_LDA_IMM, random_bcd());
			run_op("bcd carry", ($urandom % 2) ? OPC_SEC : OPC_CLC, 8'h00);
			run_op("bcd arith", ($urandom % 2) ? OPC_SBC_IMM : OPC_ADC_IMM, random_bcd());
		end
		run_op("decimal off", OPC_CLD, 8'h00);
		run_op("binary again load", OPC_LDA_IMM, 8'h7f);
		run_op("binary again carry", OPC_CLC, 8'h00);
		run_op("binary overflow", OPC_ADC_IMM, 8'h01);	// 7F + 1 sets V
		run_op("clear overflow", OPC_CLV, 8'h00);
		for (i = 0; i < 300; i++) begin	// Mix with unknown opcodes, D kept clear
			opc = ($urandom % 2) ? kept_ops[int'($urandom % 15)] : 8'($urandom);
			if (opc == OPC_SED)
				opc = OPC_CLD;
			run_op($sformatf("mix op %02h", opc), opc, 8'($urandom));
		end
		@(negedge clk);	// Checker has seen the last done
		compare_value("checked count", 32'(issued_count), 32'(checked_count));
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* vlog.f */
source/cpu6502_pkg.sv
source/op_decode.sv
source/arith_unit.sv
source/logic_shift_unit.sv
source/status_writeback.sv
source/alu_exec_top.sv
dv/tb_alu_exec.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the execute core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_alu_exec -o tb_alu_exec \
	> sim.log 2>&1 && ./obj_dir/tb_alu_exec >> sim.log 2>&1 \
	|| echo "Build or simulation returned an error status" >> sim.log
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0
